//--- hw/dram_pkg.sv
package dram_pkg;

  // processor side
  localparam int ADDR_W   = 32;
  localparam int WORD_W   = 32;
  localparam int MASK_W   = 4;          // one write enable per byte
  localparam int BYTE_W   = 8;
  localparam int OFFSET_W = 2;          // byte offset within a word

  // axi side, only lanes 0 to 3 carry data
  localparam int AXI_DATA_W = 128;
  localparam int AXI_STRB_W = AXI_DATA_W / BYTE_W;

  // model storage, upper address bits wrap
  localparam int MEM_WORDS_LOG2 = 8;
  localparam int MEM_WORDS      = 2 ** MEM_WORDS_LOG2;

  // cycles from reset release until calib_done
  localparam int                CALIB_W      = 16;
  localparam logic [CALIB_W-1:0] CALIB_CYCLES = 16'd20;

  // wait states per channel, 0 to 3 cycles
  localparam int WAIT_MAX_LOG2 = 2;

  localparam int               LFSR_W    = 16;
  localparam logic [LFSR_W-1:0] LFSR_SEED = 16'hace1;  // any nonzero value

endpackage

//--- hw/dram_axi_bridge.sv
`timescale 1ns/1ps

module dram_axi_bridge (
  input  logic                            clk,
  input  logic                            arst_n,
  // processor request
  input  logic                            dram_oe,
  input  logic [dram_pkg::ADDR_W-1:0]     dram_addr,
  input  logic [dram_pkg::WORD_W-1:0]     dram_wdata,
  input  logic [dram_pkg::MASK_W-1:0]     dram_we,
  output logic [dram_pkg::WORD_W-1:0]     dram_rdata,
  output logic                            dram_valid,
  output logic                            dram_written,
  // read address
  output logic [dram_pkg::ADDR_W-1:0]     araddr,
  output logic                            arvalid,
  input  logic                            arready,
  // read data, always accepted
  input  logic [dram_pkg::AXI_DATA_W-1:0] rdata,
  input  logic                            rvalid,
  // write address
  output logic [dram_pkg::ADDR_W-1:0]     awaddr,
  output logic                            awvalid,
  input  logic                            awready,
  // write data
  output logic [dram_pkg::AXI_DATA_W-1:0] wdata,
  output logic [dram_pkg::AXI_STRB_W-1:0] wstrb,
  output logic                            wvalid,
  input  logic                            wready,
  // write response, always accepted
  input  logic                            bvalid
);
  import dram_pkg::*;

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_READ,
    ST_WRITE
  } state_t;

  state_t              state;
  logic                start_rd;
  logic                start_wr;
  logic [OFFSET_W-1:0] req_off;
  logic [OFFSET_W-1:0] rd_off;     // offset of the open load
  logic [ADDR_W-1:0]   bus_addr;
  logic [WORD_W-1:0]   wdata_lane;
  logic [MASK_W-1:0]   wstrb_lane;

  assign req_off  = dram_addr[OFFSET_W-1:0];
  assign bus_addr = {dram_addr[ADDR_W-1:OFFSET_W], {OFFSET_W{1'b0}}};

  // a store wins over a load, mask bit 0 decides
  assign start_wr = (state == ST_IDLE) && dram_we[0];
  assign start_rd = (state == ST_IDLE) && dram_oe && !dram_we[0];

  // shifted by the byte offset, mask cut to 4 bits
  assign wdata_lane = dram_wdata << (BYTE_W * req_off);
  assign wstrb_lane = dram_we << req_off;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state        <= ST_IDLE;
      arvalid      <= 1'b0;
      awvalid      <= 1'b0;
      wvalid       <= 1'b0;
      dram_valid   <= 1'b0;
      dram_written <= 1'b0;
    end else begin
      dram_valid   <= 1'b0;
      dram_written <= 1'b0;
      case (state)
        ST_IDLE: begin
          if (start_wr) begin
            state   <= ST_WRITE;
            awvalid <= 1'b1;
            wvalid  <= 1'b1;
          end else if (start_rd) begin
            state   <= ST_READ;
            arvalid <= 1'b1;
          end
        end
        ST_READ: begin
          if (arvalid && arready) arvalid <= 1'b0;
          if (rvalid) begin
            state      <= ST_IDLE;
            dram_valid <= 1'b1;  // one cycle pulse
          end
        end
        ST_WRITE: begin
          // aw and w may complete in any order
          if (awvalid && awready) awvalid <= 1'b0;
          if (wvalid && wready) wvalid <= 1'b0;
          if (bvalid) begin
            state        <= ST_IDLE;
            dram_written <= 1'b1;
          end
        end
        default: state <= ST_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (start_rd) begin
      araddr <= bus_addr;
      rd_off <= req_off;
    end
    if (start_wr) begin
      awaddr <= bus_addr;
      wdata  <= AXI_DATA_W'(wdata_lane);  // upper lanes zero
      wstrb  <= AXI_STRB_W'(wstrb_lane);
    end
    // zero fill from the top
    if (state == ST_READ && rvalid) begin
      dram_rdata <= rdata[WORD_W-1:0] >> (BYTE_W * rd_off);
    end
  end

endmodule

//--- hw/axi_line_ram.sv
`timescale 1ns/1ps

module axi_line_ram (
  input  logic                            clk,
  input  logic                            arst_n,
  // read address
  input  logic [dram_pkg::ADDR_W-1:0]     araddr,
  input  logic                            arvalid,
  output logic                            arready,
  // read data
  output logic [dram_pkg::AXI_DATA_W-1:0] rdata,
  output logic                            rvalid,
  // write address
  input  logic [dram_pkg::ADDR_W-1:0]     awaddr,
  input  logic                            awvalid,
  output logic                            awready,
  // write data
  input  logic [dram_pkg::AXI_DATA_W-1:0] wdata,
  input  logic [dram_pkg::AXI_STRB_W-1:0] wstrb,
  input  logic                            wvalid,
  output logic                            wready,
  // write response
  output logic                            bvalid,
  output logic                            calib_done
);
  import dram_pkg::*;

  logic [WORD_W-1:0]         mem [MEM_WORDS];
  logic [LFSR_W-1:0]         lfsr;
  logic                      lfsr_fb;
  logic [CALIB_W-1:0]        calib_cnt;

  logic [WAIT_MAX_LOG2-1:0]  ar_cnt;
  logic [WAIT_MAX_LOG2-1:0]  aw_cnt;
  logic [WAIT_MAX_LOG2-1:0]  w_cnt;
  logic [WAIT_MAX_LOG2-1:0]  r_cnt;
  logic [WAIT_MAX_LOG2-1:0]  b_cnt;
  logic [WAIT_MAX_LOG2-1:0]  ar_draw;
  logic [WAIT_MAX_LOG2-1:0]  aw_draw;
  logic [WAIT_MAX_LOG2-1:0]  w_draw;
  logic [WAIT_MAX_LOG2-1:0]  r_draw;
  logic [WAIT_MAX_LOG2-1:0]  b_draw;

  logic                      ar_hs;
  logic                      aw_hs;
  logic                      w_hs;
  logic                      rd_pend;
  logic                      wr_pend;
  logic                      aw_got;   // aw taken, waiting for w
  logic                      w_got;    // w taken, waiting for aw
  logic                      wr_go;

  logic [MEM_WORDS_LOG2-1:0] rd_idx;
  logic [MEM_WORDS_LOG2-1:0] aw_idx;
  logic [WORD_W-1:0]         w_data;
  logic [MASK_W-1:0]         w_strb;
  logic [MEM_WORDS_LOG2-1:0] wr_idx;
  logic [WORD_W-1:0]         wr_data;
  logic [MASK_W-1:0]         wr_strb;

  // x^16 + x^14 + x^13 + x^11
  assign lfsr_fb = lfsr[LFSR_W-1] ^ lfsr[LFSR_W-3] ^ lfsr[LFSR_W-4] ^ lfsr[LFSR_W-6];

  // separate fields so channels stall independently
  assign ar_draw = lfsr[0 +: WAIT_MAX_LOG2];
  assign aw_draw = lfsr[3 +: WAIT_MAX_LOG2];
  assign w_draw  = lfsr[6 +: WAIT_MAX_LOG2];
  assign r_draw  = lfsr[9 +: WAIT_MAX_LOG2];
  assign b_draw  = lfsr[12 +: WAIT_MAX_LOG2];

  assign arready = calib_done && arvalid && !rd_pend && (ar_cnt == '0);
  assign awready = calib_done && awvalid && !aw_got && !wr_pend && (aw_cnt == '0);
  assign wready  = calib_done && wvalid && !w_got && !wr_pend && (w_cnt == '0);

  assign ar_hs = arvalid && arready;
  assign aw_hs = awvalid && awready;
  assign w_hs  = wvalid && wready;

  assign rvalid = rd_pend && (r_cnt == '0);
  assign rdata  = AXI_DATA_W'(mem[rd_idx]);  // lanes 0 to 3 only
  assign bvalid = wr_pend && (b_cnt == '0);

  // second of aw/w arriving, take the live channel values
  assign wr_go   = (aw_got || aw_hs) && (w_got || w_hs);
  assign wr_idx  = aw_got ? aw_idx : awaddr[OFFSET_W +: MEM_WORDS_LOG2];
  assign wr_data = w_got ? w_data : wdata[WORD_W-1:0];
  assign wr_strb = w_got ? w_strb : wstrb[MASK_W-1:0];

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      lfsr       <= LFSR_SEED;
      calib_cnt  <= '0;
      calib_done <= 1'b0;
      ar_cnt     <= '0;
      aw_cnt     <= '0;
      w_cnt      <= '0;
      r_cnt      <= '0;
      b_cnt      <= '0;
      rd_pend    <= 1'b0;
      wr_pend    <= 1'b0;
      aw_got     <= 1'b0;
      w_got      <= 1'b0;
    end else begin
      lfsr <= {lfsr[LFSR_W-2:0], lfsr_fb};

      if (!calib_done) begin
        calib_cnt <= calib_cnt + 1'b1;
        if (calib_cnt == CALIB_CYCLES - 1'b1) calib_done <= 1'b1;
      end

      // ready wait counts run down while valid is held
      if (ar_hs) ar_cnt <= ar_draw;
      else if (arvalid && calib_done && ar_cnt != '0) ar_cnt <= ar_cnt - 1'b1;
      if (aw_hs) aw_cnt <= aw_draw;
      else if (awvalid && calib_done && aw_cnt != '0) aw_cnt <= aw_cnt - 1'b1;
      if (w_hs) w_cnt <= w_draw;
      else if (wvalid && calib_done && w_cnt != '0) w_cnt <= w_cnt - 1'b1;

      if (ar_hs) begin
        rd_pend <= 1'b1;
        r_cnt   <= r_draw;
      end else if (rvalid) begin
        rd_pend <= 1'b0;
      end else if (rd_pend) begin
        r_cnt <= r_cnt - 1'b1;
      end

      if (wr_go) begin
        aw_got  <= 1'b0;
        w_got   <= 1'b0;
        wr_pend <= 1'b1;
        b_cnt   <= b_draw;
      end else if (bvalid) begin
        wr_pend <= 1'b0;
      end else if (wr_pend) begin
        b_cnt <= b_cnt - 1'b1;
      end else begin
        if (aw_hs) aw_got <= 1'b1;
        if (w_hs) w_got <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (ar_hs) rd_idx <= araddr[OFFSET_W +: MEM_WORDS_LOG2];
    if (aw_hs) aw_idx <= awaddr[OFFSET_W +: MEM_WORDS_LOG2];
    if (w_hs) begin
      w_data <= wdata[WORD_W-1:0];
      w_strb <= wstrb[MASK_W-1:0];
    end
    if (wr_go) begin
      for (int b = 0; b < MASK_W; b++) begin
        if (wr_strb[b]) mem[wr_idx][BYTE_W*b +: BYTE_W] <= wr_data[BYTE_W*b +: BYTE_W];
      end
    end
  end

endmodule

//--- hw/dram_top.sv
`timescale 1ns/1ps

module dram_top (
  input  logic                        clk,
  input  logic                        arst_n,
  input  logic                        dram_oe,
  input  logic [dram_pkg::ADDR_W-1:0] dram_addr,
  input  logic [dram_pkg::WORD_W-1:0] dram_wdata,
  input  logic [dram_pkg::MASK_W-1:0] dram_we,
  output logic [dram_pkg::WORD_W-1:0] dram_rdata,
  output logic                        dram_valid,
  output logic                        dram_written,
  output logic                        calib_done
);
  import dram_pkg::*;

  logic [ADDR_W-1:0]     araddr;
  logic                  arvalid;
  logic                  arready;
  logic [AXI_DATA_W-1:0] rdata;
  logic                  rvalid;
  logic [ADDR_W-1:0]     awaddr;
  logic                  awvalid;
  logic                  awready;
  logic [AXI_DATA_W-1:0] wdata;
  logic [AXI_STRB_W-1:0] wstrb;
  logic                  wvalid;
  logic                  wready;
  logic                  bvalid;

  dram_axi_bridge dram_axi_bridge_inst (
    .clk          (clk),
    .arst_n       (arst_n),
    .dram_oe      (dram_oe),
    .dram_addr    (dram_addr),
    .dram_wdata   (dram_wdata),
    .dram_we      (dram_we),
    .dram_rdata   (dram_rdata),
    .dram_valid   (dram_valid),
    .dram_written (dram_written),
    .araddr       (araddr),
    .arvalid      (arvalid),
    .arready      (arready),
    .rdata        (rdata),
    .rvalid       (rvalid),
    .awaddr       (awaddr),
    .awvalid      (awvalid),
    .awready      (awready),
    .wdata        (wdata),
    .wstrb        (wstrb),
    .wvalid       (wvalid),
    .wready       (wready),
    .bvalid       (bvalid)
  );

  // stands in for the external controller
  axi_line_ram axi_line_ram_inst (
    .clk        (clk),
    .arst_n     (arst_n),
    .araddr     (araddr),
    .arvalid    (arvalid),
    .arready    (arready),
    .rdata      (rdata),
    .rvalid     (rvalid),
    .awaddr     (awaddr),
    .awvalid    (awvalid),
    .awready    (awready),
    .wdata      (wdata),
    .wstrb      (wstrb),
    .wvalid     (wvalid),
    .wready     (wready),
    .bvalid     (bvalid),
    .calib_done (calib_done)
  );

endmodule

//--- include/tb_checks.svh
`ifndef TB_CHECKS_SVH
`define TB_CHECKS_SVH

// byte image of the model memory, word index times 4 plus lane
logic [dram_pkg::BYTE_W-1:0] ref_mem [dram_pkg::MEM_WORDS * dram_pkg::MASK_W];

task automatic report_error(input string msg);
  $display("ERR %0t: %s", $time, msg);
  $display("Regression failed");
  $fatal(1);
endtask

task automatic check_word(input logic [dram_pkg::WORD_W-1:0] got,
                          input logic [dram_pkg::WORD_W-1:0] exp,
                          input string what);
  if (got !== exp) begin
    report_error($sformatf("%s: read %08h, expected %08h", what, got, exp));
  end
endtask

// high_cycles counts how long the completion flag stayed up
task automatic check_flag(input int high_cycles, input string what);
  if (high_cycles == 0) report_error($sformatf("%s: no completion pulse", what));
  else if (high_cycles != 1) begin
    report_error($sformatf("%s: pulse lasted %0d cycles", what, high_cycles));
  end
endtask

// same shift and cut as the bridge
task automatic ref_store(input logic [dram_pkg::ADDR_W-1:0] addr,
                         input logic [dram_pkg::WORD_W-1:0] data,
                         input logic [dram_pkg::MASK_W-1:0] mask);
  int unsigned                   base;
  logic [dram_pkg::WORD_W-1:0]   d;
  logic [dram_pkg::MASK_W-1:0]   m;
  base = addr[dram_pkg::OFFSET_W +: dram_pkg::MEM_WORDS_LOG2] * dram_pkg::MASK_W;
  d    = data << (dram_pkg::BYTE_W * addr[dram_pkg::OFFSET_W-1:0]);
  m    = mask << addr[dram_pkg::OFFSET_W-1:0];
  for (int b = 0; b < dram_pkg::MASK_W; b++) begin
    if (m[b]) ref_mem[base + b] = d[dram_pkg::BYTE_W*b +: dram_pkg::BYTE_W];
  end
endtask

function automatic logic [dram_pkg::WORD_W-1:0] ref_load(
    input logic [dram_pkg::ADDR_W-1:0] addr);
  int unsigned                 base;
  logic [dram_pkg::WORD_W-1:0] w;
  base = addr[dram_pkg::OFFSET_W +: dram_pkg::MEM_WORDS_LOG2] * dram_pkg::MASK_W;
  for (int b = 0; b < dram_pkg::MASK_W; b++) begin
    w[dram_pkg::BYTE_W*b +: dram_pkg::BYTE_W] = ref_mem[base + b];
  end
  return w >> (dram_pkg::BYTE_W * addr[dram_pkg::OFFSET_W-1:0]);
endfunction

`endif

//--- tests/tb_dram_top.sv
`timescale 1ns/1ps

module tb_dram_top;
  import dram_pkg::*;

  localparam int PAT_MAX    = 64;
  localparam int PAT_FIELDS = 5;    // op, address, data, mask, expected
  localparam int N_FILL     = 16;   // full words written before random traffic
  localparam int N_RAND     = 200;
  localparam int RST_CYCLES = 3;
  localparam int CYC_PER_OP = 20;

  localparam int OP_END      = 0;
  localparam int OP_STORE    = 1;
  localparam int OP_LOAD     = 2;
  localparam int OP_STORE_OE = 3;   // store with dram_oe also high

  logic              clk;
  logic              arst_n;
  logic              dram_oe;
  logic [ADDR_W-1:0] dram_addr;
  logic [WORD_W-1:0] dram_wdata;
  logic [MASK_W-1:0] dram_we;
  logic [WORD_W-1:0] dram_rdata;
  logic              dram_valid;
  logic              dram_written;
  logic              calib_done;

  logic [31:0] pat_mem [PAT_MAX * PAT_FIELDS];
  logic [31:0] lcg_state;
  int          n_pat;
  int          limit_cycles;
  logic        calib_seen;

  `include "tb_checks.svh"

  dram_top dram_top_inst (
    .clk          (clk),
    .arst_n       (arst_n),
    .dram_oe      (dram_oe),
    .dram_addr    (dram_addr),
    .dram_wdata   (dram_wdata),
    .dram_we      (dram_we),
    .dram_rdata   (dram_rdata),
    .dram_valid   (dram_valid),
    .dram_written (dram_written),
    .calib_done   (calib_done)
  );

  always #20 clk = ~clk;

  function automatic logic [31:0] next_rand();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  // called on a falling edge, returns on the falling edge after the pulse
  task automatic run_op(input logic              is_store,
                        input logic              oe,
                        input logic [ADDR_W-1:0] addr,
                        input logic [WORD_W-1:0] data,
                        input logic [MASK_W-1:0] mask,
                        input logic [WORD_W-1:0] exp,
                        input string             what);
    int                wait_cycles;
    int                high_cycles;
    logic [WORD_W-1:0] got;
    wait_cycles = 1;
    high_cycles = 0;
    got         = '0;
    dram_oe     = oe;
    dram_addr   = addr;
    dram_wdata  = data;
    dram_we     = mask;
    @(negedge clk);
    dram_oe = 1'b0;   // one cycle request
    dram_we = '0;
    while (!(is_store ? dram_written : dram_valid) && wait_cycles < CYC_PER_OP) begin
      if (is_store ? dram_valid : dram_written) begin
        report_error($sformatf("%s: completion pulse of the wrong kind", what));
      end
      @(negedge clk);
      wait_cycles++;
    end
    if (wait_cycles < 3) begin
      report_error($sformatf("%s: completion after only %0d cycles", what, wait_cycles));
    end
    got = dram_rdata;
    while (is_store ? dram_written : dram_valid) begin
      high_cycles++;
      @(negedge clk);
    end
    check_flag(high_cycles, what);
    if (!is_store) check_word(got, exp, what);
  endtask

  task automatic run_patterns();
    int          base;
    logic [31:0] op;
    for (int i = 0; i < n_pat; i++) begin
      base = i * PAT_FIELDS;
      op   = pat_mem[base];
      if (op == OP_LOAD) begin
        run_op(1'b0, 1'b1, pat_mem[base+1], pat_mem[base+2], pat_mem[base+3][MASK_W-1:0],
               pat_mem[base+4], $sformatf("pattern %0d load", i));
      end else if (op == OP_STORE || op == OP_STORE_OE) begin
        ref_store(pat_mem[base+1], pat_mem[base+2], pat_mem[base+3][MASK_W-1:0]);
        run_op(1'b1, op == OP_STORE_OE, pat_mem[base+1], pat_mem[base+2],
               pat_mem[base+3][MASK_W-1:0], '0, $sformatf("pattern %0d store", i));
      end else begin
        report_error($sformatf("pattern %0d has unknown op %0h", i, op));
      end
    end
  endtask

  // word indices 0x80 to 0x8f, random bits above the stored range
  task automatic run_random();
    logic [31:0]       r;
    logic [31:0]       hi;
    logic [ADDR_W-1:0] addr;
    logic [WORD_W-1:0] data;
    logic [MASK_W-1:0] mask;
    for (int i = 0; i < N_FILL + N_RAND; i++) begin
      r    = next_rand();
      hi   = next_rand();
      data = next_rand();
      if (i < N_FILL) begin
        addr = {hi[31:10], 4'h8, i[3:0], 2'b00};
        ref_store(addr, data, 4'hf);
        run_op(1'b1, 1'b0, addr, data, 4'hf, '0, $sformatf("fill %0d", i));
      end else begin
        addr = {hi[31:10], 4'h8, r[3:0], r[5:4]};
        if (r[31]) begin
          mask = r[11:8] | 4'h1;
          ref_store(addr, data, mask);
          run_op(1'b1, r[12], addr, data, mask, '0, $sformatf("random %0d store", i));
        end else begin
          mask = r[11:8] & 4'he;   // bit 0 clear keeps it a load
          run_op(1'b0, 1'b1, addr, data, mask, ref_load(addr),
                 $sformatf("random %0d load", i));
        end
      end
    end
  endtask

  always @(negedge clk) begin
    if (calib_seen && !calib_done) report_error("calib_done fell after rising");
  end

  initial begin
    wait (arst_n === 1'b1 && limit_cycles != 0);
    repeat (limit_cycles) @(posedge clk);
    $display("run timed out waiting for the DUT");
    $display("Regression failed");
    $fatal(1);
  end

  initial begin
    clk          = 1'b0;
    arst_n       = 1'b0;
    dram_oe      = 1'b0;
    dram_addr    = '0;
    dram_wdata   = '0;
    dram_we      = '0;
    lcg_state    = 32'd34299;
    calib_seen   = 1'b0;
    n_pat        = 0;
    limit_cycles = 0;
    $readmemh("tests/dram_patterns.hex", pat_mem);
    while (n_pat < PAT_MAX && pat_mem[n_pat * PAT_FIELDS] != OP_END) n_pat++;
    limit_cycles = (n_pat + N_FILL + N_RAND) * CYC_PER_OP + int'(CALIB_CYCLES);

    repeat (RST_CYCLES) @(negedge clk);
    if (calib_done || dram_valid || dram_written) report_error("outputs high during reset");
    arst_n = 1'b1;
    @(negedge clk);
    if (calib_done || dram_valid || dram_written) report_error("outputs high after reset");
    while (!calib_done) @(negedge clk);
    calib_seen = 1'b1;

    run_patterns();
    run_random();
    $display("Regression passed");
    $finish;
  end

endmodule

//--- tests/dram_patterns.hex
// op (1 store, 2 load, 3 store with oe high, 0 end), address, data, mask,
// expected load word (zero for stores)
// full word store then load
1 00000000 11223344 f 00000000
2 00000000 00000000 0 11223344
// partial masks at nonzero offsets merge into word 0x10
1 00000010 a1b2c3d4 f 00000000
1 00000011 000000ee 1 00000000
2 00000010 00000000 0 a1b2eed4
3 00000013 55667788 3 00000000
2 00000010 00000000 0 88b2eed4
1 00000012 0000abcd 3 00000000
2 00000010 00000000 0 abcdeed4
2 00000011 00000000 0 00abcdee
// load offsets with zero fill
1 00000020 deadbeef f 00000000
2 00000021 00000000 0 00deadbe
2 00000022 00000000 0 0000dead
2 00000023 00000000 0 000000de
// mask without bit 0 and oe high is a load
2 00000020 00000000 e deadbeef
// mask cut to 4 bits after the shift
1 00000030 01234567 f 00000000
1 00000031 000000aa f 00000000
2 00000030 00000000 0 0000aa67
3 00000030 ffffffff 5 00000000
2 00000032 00000000 0 000000ff
2 00000030 00000000 0 00ffaaff
// addresses above the stored range alias
1 00000040 cafef00d f 00000000
2 00000440 00000000 0 cafef00d
1 00000c40 12345678 f 00000000
2 80000040 00000000 0 12345678
2 00000041 00000000 6 00123456
// end of records
0 00000000 00000000 0 00000000

//--- src.f
+incdir+include
hw/dram_pkg.sv
hw/dram_axi_bridge.sv
hw/axi_line_ram.sv
hw/dram_top.sv
tests/tb_dram_top.sv

//--- run.sh
#!/usr/bin/env bash
# build and run the testbench with Verilator from the project root
cd "$(dirname "$0")" \
  && verilator --binary --timing --top-module tb_dram_top -f src.f -o tb_dram_top \
  && ./obj_dir/tb_dram_top \
  || { echo "simulation build or run did not succeed"; exit 1; }
